// ==== mips_exc.f ====
src/mips_pkg.sv
src/commit_queue.sv
src/exception.sv
src/cp0_regs.sv
src/retire_unit.sv
src/exc_top.sv
testbench/tb_exc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the exception back end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f mips_exc.f \
    --top-module tb_exc_top \
    -o tb_exc_top

output=$(./obj_dir/tb_exc_top 2>&1 || true)
echo "$output"

if grep -qxF ">>> PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== src/commit_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_queue (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    // producer side
    input  wire logic                          in_valid,
    output logic                               in_ready,
    input  wire logic [mips_pkg::rec_width-1:0] in_record,
    // consumer side
    output logic                               head_valid,
    output logic [mips_pkg::rec_width-1:0]     head_record,
    input  wire logic                          head_pop
);

    logic [mips_pkg::rec_width-1:0] mem [mips_pkg::queue_depth];

    mips_pkg::qptr_t   wr_ptr;
    mips_pkg::qptr_t   rd_ptr;
    mips_pkg::qcount_t count;

    logic push;
    logic pop;

    assign in_ready   = (count != mips_pkg::queue_full);
    assign head_valid = (count != '0);

    assign push = in_valid & in_ready;
    assign pop  = head_pop & head_valid;

    // head comes straight from storage, no input bypass
    assign head_record = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_record;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [mips_pkg::ext_int_width-1:0] ext_int,
    // exception entry
    input  wire logic                               take_exc,
    input  wire mips_pkg::exc_code_t                exc_code,
    input  wire mips_pkg::word_t                    exc_pc,
    input  wire logic                               exc_delay_slot,
    input  wire mips_pkg::word_t                    exc_vaddr,
    // return and software writes
    input  wire logic                               do_eret,
    input  wire logic                               wr_status,
    input  wire logic                               wr_cause,
    input  wire mips_pkg::word_t                    wr_data,
    // state seen by the retire unit
    output logic                                    status_ie,
    output logic                                    status_exl,
    output logic                                    status_erl,
    output mips_pkg::status_im_t                    status_im,
    output mips_pkg::status_im_t                    cause_ip,
    output mips_pkg::word_t                         epc
);

    logic                               cause_bd;
    mips_pkg::exc_code_t                cause_exccode;
    logic [mips_pkg::ext_int_width-1:0] cause_ip_hw;
    logic [1:0]                         cause_ip_sw;
    mips_pkg::word_t                    badvaddr;

    logic addr_error;

    assign cause_ip = {cause_ip_hw, cause_ip_sw};

    assign addr_error = (exc_code == mips_pkg::code_adel)
                      | (exc_code == mips_pkg::code_ades);

    // Status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_ie  <= mips_pkg::status_ie_rst;
            status_exl <= mips_pkg::status_exl_rst;
            status_erl <= mips_pkg::status_erl_rst;
            status_im  <= mips_pkg::status_im_rst;
        end else if (take_exc) begin
            status_exl <= 1'b1;
        end else if (do_eret) begin
            // leave error level first, exception level otherwise
            if (status_erl) begin
                status_erl <= 1'b0;
            end else begin
                status_exl <= 1'b0;
            end
        end else if (wr_status) begin
            status_ie  <= wr_data[0];
            status_exl <= wr_data[1];
            status_erl <= wr_data[2];
            status_im  <= wr_data[15:8];
        end
    end

    // Cause.IP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cause_ip_hw <= '0;
            cause_ip_sw <= '0;
        end else begin
            // hardware lines sampled every cycle
            cause_ip_hw <= ext_int;
            if (wr_cause) begin
                cause_ip_sw <= wr_data[9:8];
            end
        end
    end

    // registers loaded on exception entry
    always_ff @(posedge clk) begin
        if (take_exc) begin
            cause_bd      <= exc_delay_slot;
            cause_exccode <= exc_code;
            // restart at the branch when the victim sits in its delay slot
            epc <= exc_delay_slot ? (exc_pc - 32'd4) : exc_pc;
            if (addr_error) begin
                badvaddr <= exc_vaddr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/exc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [mips_pkg::ext_int_width-1:0] ext_int,
    // commit record input
    input  wire logic                               in_valid,
    output logic                                    in_ready,
    input  wire mips_pkg::word_t                    in_pc,
    input  wire logic                               in_delay_slot,
    input  wire mips_pkg::rec_kind_t                in_kind,
    input  wire mips_pkg::fault_t                   in_faults,
    input  wire mips_pkg::word_t                    in_vaddr,
    input  wire mips_pkg::word_t                    in_data,
    // retirement outcome
    output logic                                    out_valid,
    input  wire logic                               out_ready,
    output mips_pkg::word_t                         out_pc,
    output logic                                    out_exc,
    output mips_pkg::exc_code_t                     out_code,
    output logic                                    out_redirect,
    output mips_pkg::word_t                         out_redirect_pc
);

    logic [mips_pkg::rec_width-1:0] in_record;
    logic [mips_pkg::rec_width-1:0] head_record;
    logic                           head_valid;
    logic                           head_pop;

    logic                 take_exc;
    mips_pkg::exc_code_t  exc_code;
    mips_pkg::word_t      exc_pc;
    logic                 exc_delay_slot;
    mips_pkg::word_t      exc_vaddr;
    logic                 do_eret;
    logic                 wr_status;
    logic                 wr_cause;
    mips_pkg::word_t      wr_data;
    logic                 status_ie;
    logic                 status_exl;
    logic                 status_erl;
    mips_pkg::status_im_t status_im;
    mips_pkg::status_im_t cause_ip;
    mips_pkg::word_t      epc;

    // same field order the retire unit unpacks
    assign in_record = {in_pc, in_delay_slot, in_kind, in_faults, in_vaddr, in_data};

    commit_queue commit_queue_i (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_record (in_record),
        .head_valid (head_valid), .head_record (head_record), .head_pop (head_pop)
    );

    retire_unit retire_unit_i (
        .clk (clk), .rst_n (rst_n),
        .head_valid (head_valid), .head_record (head_record), .head_pop (head_pop),
        .take_exc (take_exc), .exc_code (exc_code), .exc_pc (exc_pc),
        .exc_delay_slot (exc_delay_slot), .exc_vaddr (exc_vaddr), .do_eret (do_eret),
        .wr_status (wr_status), .wr_cause (wr_cause), .wr_data (wr_data),
        .status_ie (status_ie), .status_exl (status_exl), .status_erl (status_erl),
        .status_im (status_im), .cause_ip (cause_ip), .epc (epc),
        .out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
        .out_exc (out_exc), .out_code (out_code), .out_redirect (out_redirect),
        .out_redirect_pc (out_redirect_pc)
    );

    cp0_regs cp0_regs_i (
        .clk (clk), .rst_n (rst_n), .ext_int (ext_int),
        .take_exc (take_exc), .exc_code (exc_code), .exc_pc (exc_pc),
        .exc_delay_slot (exc_delay_slot), .exc_vaddr (exc_vaddr), .do_eret (do_eret),
        .wr_status (wr_status), .wr_cause (wr_cause), .wr_data (wr_data),
        .status_ie (status_ie), .status_exl (status_exl), .status_erl (status_erl),
        .status_im (status_im), .cause_ip (cause_ip), .epc (epc)
    );

endmodule

`default_nettype wire

// ==== src/exception.sv ====
`timescale 1ns/1ps
`default_nettype none

module exception (
    input  wire mips_pkg::fault_t     faults,
    input  wire logic                 in_delay_slot,
    input  wire mips_pkg::status_im_t cause_ip,
    input  wire mips_pkg::status_im_t status_im,
    input  wire logic                 status_ie,
    input  wire logic                 status_exl,
    input  wire logic                 status_erl,
    output logic                      exception_valid,
    output mips_pkg::exc_code_t       exccode,
    // BD value to record, only meaningful with exception_valid
    output logic                      exc_delay_slot
);

    logic interrupt_valid;

    // pending and unmasked, and not already at exception or error level
    assign interrupt_valid = (|(cause_ip & status_im))
                           & status_ie
                           & ~status_exl
                           & ~status_erl;

    always_comb begin
        exception_valid = 1'b1;
        if (interrupt_valid) begin
            exccode = mips_pkg::code_int;
        end else if (faults.instr_adel) begin
            exccode = mips_pkg::code_adel;
        end else if (faults.ri) begin
            exccode = mips_pkg::code_ri;
        end else if (faults.ov) begin
            exccode = mips_pkg::code_ov;
        end else if (faults.sys) begin
            exccode = mips_pkg::code_sys;
        end else if (faults.bp) begin
            exccode = mips_pkg::code_bp;
        end else if (faults.load_adel) begin
            // data side, same code as fetch
            exccode = mips_pkg::code_adel;
        end else if (faults.save_ades) begin
            exccode = mips_pkg::code_ades;
        end else begin
            exception_valid = 1'b0;
            exccode = '0;
        end
    end

    assign exc_delay_slot = exception_valid & in_delay_slot;

endmodule

`default_nettype wire

// ==== src/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // machine word
    localparam int word_width = 32;
    typedef logic [word_width-1:0] word_t;

    // Cause.ExcCode
    localparam int exc_code_width = 5;
    typedef logic [exc_code_width-1:0] exc_code_t;

    localparam exc_code_t code_int  = 5'd0;
    localparam exc_code_t code_adel = 5'd4;
    localparam exc_code_t code_ades = 5'd5;
    localparam exc_code_t code_sys  = 5'd8;
    localparam exc_code_t code_bp   = 5'd9;
    localparam exc_code_t code_ri   = 5'd10;
    localparam exc_code_t code_ov   = 5'd12;

    // general exception vector, BEV=1
    localparam word_t exc_entry = 32'hbfc0_0380;

    // what the record does on retirement when it does not fault
    localparam int kind_width = 2;
    typedef enum logic [kind_width-1:0] {
        kind_plain,
        kind_eret,
        kind_mtc0_status,
        kind_mtc0_cause
    } rec_kind_t;

    // faults detected upstream, msb first
    localparam int fault_width = 7;
    typedef struct packed {
        logic instr_adel;
        logic ri;
        logic ov;
        logic sys;
        logic bp;
        logic load_adel;
        logic save_ades;
    } fault_t;

    // pc, in_delay_slot, kind, faults, vaddr, data
    localparam int rec_width = word_width + 1 + kind_width + fault_width + 2 * word_width;

    // commit queue sizing
    localparam int queue_depth = 4;
    localparam int ptr_width   = $clog2(queue_depth);
    localparam int count_width = $clog2(queue_depth + 1);
    typedef logic [ptr_width-1:0] qptr_t;
    typedef logic [count_width-1:0] qcount_t;
    localparam qcount_t queue_full = qcount_t'(queue_depth);

    // interrupt mask / pending bits
    typedef logic [7:0] status_im_t;

    // hardware interrupt lines
    localparam int ext_int_width = 6;

    // Status after reset: error level, interrupts off
    localparam logic       status_erl_rst = 1'b1;
    localparam logic       status_exl_rst = 1'b0;
    localparam logic       status_ie_rst  = 1'b0;
    localparam status_im_t status_im_rst  = 8'h00;

endpackage

`default_nettype wire

// ==== src/retire_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    // queue head
    input  wire logic                           head_valid,
    input  wire logic [mips_pkg::rec_width-1:0] head_record,
    output logic                                head_pop,
    // cp0 control
    output logic                                take_exc,
    output mips_pkg::exc_code_t                 exc_code,
    output mips_pkg::word_t                     exc_pc,
    output logic                                exc_delay_slot,
    output mips_pkg::word_t                     exc_vaddr,
    output logic                                do_eret,
    output logic                                wr_status,
    output logic                                wr_cause,
    output mips_pkg::word_t                     wr_data,
    // cp0 state
    input  wire logic                           status_ie,
    input  wire logic                           status_exl,
    input  wire logic                           status_erl,
    input  wire mips_pkg::status_im_t           status_im,
    input  wire mips_pkg::status_im_t           cause_ip,
    input  wire mips_pkg::word_t                epc,
    // outcome port
    output logic                                out_valid,
    input  wire logic                           out_ready,
    output mips_pkg::word_t                     out_pc,
    output logic                                out_exc,
    output mips_pkg::exc_code_t                 out_code,
    output logic                                out_redirect,
    output mips_pkg::word_t                     out_redirect_pc
);

    mips_pkg::word_t     rec_pc;
    logic                rec_delay_slot;
    logic [1:0]          rec_kind_bits;
    mips_pkg::rec_kind_t rec_kind;
    mips_pkg::fault_t    rec_faults;
    mips_pkg::word_t     rec_vaddr;
    mips_pkg::word_t     rec_data;

    logic exception_valid;
    logic is_eret;

    assign {rec_pc, rec_delay_slot, rec_kind_bits, rec_faults, rec_vaddr, rec_data} = head_record;
    assign rec_kind = mips_pkg::rec_kind_t'(rec_kind_bits);

    exception exception_i (
        .faults          (rec_faults),
        .in_delay_slot   (rec_delay_slot),
        .cause_ip        (cause_ip),
        .status_im       (status_im),
        .status_ie       (status_ie),
        .status_exl      (status_exl),
        .status_erl      (status_erl),
        .exception_valid (exception_valid),
        .exccode         (exc_code),
        .exc_delay_slot  (exc_delay_slot)
    );

    // retire whenever the outcome register is empty or draining
    assign head_pop = head_valid & (~out_valid | out_ready);

    // a faulting record has no effect of its own
    assign take_exc  = head_pop & exception_valid;
    assign is_eret   = ~exception_valid & (rec_kind == mips_pkg::kind_eret);
    assign do_eret   = head_pop & is_eret;
    assign wr_status = head_pop & ~exception_valid & (rec_kind == mips_pkg::kind_mtc0_status);
    assign wr_cause  = head_pop & ~exception_valid & (rec_kind == mips_pkg::kind_mtc0_cause);
    assign wr_data   = rec_data;
    assign exc_pc    = rec_pc;
    // fetch error reports the pc itself
    assign exc_vaddr = rec_faults.instr_adel ? rec_pc : rec_vaddr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (~out_valid | out_ready) begin
            out_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            out_pc          <= rec_pc;
            out_exc         <= exception_valid;
            out_code        <= exception_valid ? exc_code : '0;
            out_redirect    <= exception_valid | is_eret;
            out_redirect_pc <= exception_valid ? mips_pkg::exc_entry : (is_eret ? epc : '0);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/exc_vectors.mem ====
// group pc ds kind faults vaddr data ext_int
// then expected outcome: pc exc code redirect redirect_pc
1_00400000_0_0_00_00000000_00000000_00_00400000_0_00_0_00000000
1_00400004_0_0_00_00000000_00000000_00_00400004_0_00_0_00000000
1_00400008_0_0_00_00000000_00000000_00_00400008_0_00_0_00000000
2_0040000c_0_0_40_00000000_00000000_00_0040000c_1_04_1_bfc00380
2_00400010_0_0_20_00000000_00000000_00_00400010_1_0a_1_bfc00380
2_00400014_0_0_10_00000000_00000000_00_00400014_1_0c_1_bfc00380
2_00400018_0_0_08_00000000_00000000_00_00400018_1_08_1_bfc00380
2_0040001c_0_0_04_00000000_00000000_00_0040001c_1_09_1_bfc00380
2_00400020_0_0_02_00001001_00000000_00_00400020_1_04_1_bfc00380
2_00400024_0_0_01_00002002_00000000_00_00400024_1_05_1_bfc00380
2_00400028_0_0_0c_00000000_00000000_00_00400028_1_08_1_bfc00380
2_0040002c_0_0_23_00003003_00000000_00_0040002c_1_0a_1_bfc00380
3_00400030_0_2_00_00000000_00000000_00_00400030_0_00_0_00000000
3_00400100_1_0_08_00000000_00000000_00_00400100_1_08_1_bfc00380
3_bfc00380_0_1_00_00000000_00000000_00_bfc00380_0_00_1_004000fc
3_00400200_0_0_04_00000000_00000000_00_00400200_1_09_1_bfc00380
3_bfc00384_0_1_00_00000000_00000000_00_bfc00384_0_00_1_00400200
4_00400300_0_3_00_00000000_00000100_00_00400300_0_00_0_00000000
4_00400304_0_0_00_00000000_00000000_00_00400304_0_00_0_00000000
4_00400308_0_2_00_00000000_00000105_00_00400308_0_00_0_00000000
4_0040030c_0_0_00_00000000_00000000_00_0040030c_0_00_0_00000000
4_00400310_0_2_00_00000000_00000501_00_00400310_0_00_0_00000000
4_00400314_0_0_10_00000000_00000000_00_00400314_1_00_1_bfc00380
4_bfc00388_0_3_00_00000000_00000000_00_bfc00388_0_00_0_00000000
4_bfc0038c_0_1_00_00000000_00000000_00_bfc0038c_0_00_1_00400314
5_00400400_0_0_00_00000000_00000000_01_00400400_1_00_1_bfc00380
5_bfc00390_0_0_00_00000000_00000000_01_bfc00390_0_00_0_00000000
5_bfc00394_0_1_00_00000000_00000000_01_bfc00394_0_00_1_00400400
6_00400500_0_2_20_00000000_00000000_00_00400500_1_0a_1_bfc00380
6_bfc00398_0_1_04_00000000_00000000_00_bfc00398_1_09_1_bfc00380
6_bfc0039c_0_1_00_00000000_00000000_00_bfc0039c_0_00_1_bfc00398
6_00400600_0_0_00_00000000_00000000_01_00400600_1_00_1_bfc00380

// ==== testbench/tb_exc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exc_top;

    localparam int num_vectors       = 32;
    localparam int cycles_per_vector = 200;
    localparam int reset_cycles      = 10;

    // one line of the vector file, each field padded to whole hex digits
    typedef struct packed {
        logic [3:0]  group;
        logic [31:0] pc;
        logic [3:0]  delay_slot;
        logic [3:0]  kind;
        logic [7:0]  faults;
        logic [31:0] vaddr;
        logic [31:0] data;
        logic [7:0]  ext_int;
        logic [31:0] exp_pc;
        logic [3:0]  exp_exc;
        logic [7:0]  exp_code;
        logic [3:0]  exp_redirect;
        logic [31:0] exp_redirect_pc;
    } vector_t;

    logic                               clk;
    logic                               rst_n;
    logic [mips_pkg::ext_int_width-1:0] ext_int;
    logic                               in_valid;
    logic                               in_ready;
    mips_pkg::word_t                    in_pc;
    logic                               in_delay_slot;
    mips_pkg::rec_kind_t                in_kind;
    mips_pkg::fault_t                   in_faults;
    mips_pkg::word_t                    in_vaddr;
    mips_pkg::word_t                    in_data;
    logic                               out_valid;
    logic                               out_ready;
    mips_pkg::word_t                    out_pc;
    logic                               out_exc;
    mips_pkg::exc_code_t                out_code;
    logic                               out_redirect;
    mips_pkg::word_t                    out_redirect_pc;

    logic [$bits(vector_t)-1:0] vec_mem [num_vectors];
    int   sent;
    int   retired;
    logic holding;

    exc_top exc_top_i (
        .clk (clk), .rst_n (rst_n), .ext_int (ext_int),
        .in_valid (in_valid), .in_ready (in_ready), .in_pc (in_pc),
        .in_delay_slot (in_delay_slot), .in_kind (in_kind), .in_faults (in_faults),
        .in_vaddr (in_vaddr), .in_data (in_data),
        .out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
        .out_exc (out_exc), .out_code (out_code), .out_redirect (out_redirect),
        .out_redirect_pc (out_redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input string field,
                              input mips_pkg::word_t expected, input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s expected %h actual %h", name, field, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input string field,
                              input mips_pkg::exc_code_t expected,
                              input mips_pkg::exc_code_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s expected %0d actual %0d", name, field, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s %s expected %b actual %b", name, field, expected, actual);
            abort_run();
        end
    endtask

    function automatic string vector_label(input int idx, input logic [3:0] group);
        string topic;
        case (group)
            4'd1:    topic = "plain_retire";
            4'd2:    topic = "fault_priority";
            4'd3:    topic = "eret_return";
            4'd4:    topic = "interrupt_mask";
            4'd5:    topic = "external_interrupt";
            default: topic = "suppressed_effect";
        endcase
        return $sformatf("%s[%0d]", topic, idx);
    endfunction

    // random back-pressure, outcome checked when it will transfer on the next edge
    task automatic collect_outcome();
        vector_t v;
        string   name;
        out_ready = ($urandom % 3) != 0;
        if (out_valid && out_ready) begin
            v    = vec_mem[retired];
            name = vector_label(retired, v.group);
            check_word(name, "pc", v.exp_pc, out_pc);
            check_flag(name, "exc", v.exp_exc[0], out_exc);
            check_code(name, "code", v.exp_code[4:0], out_code);
            check_flag(name, "redirect", v.exp_redirect[0], out_redirect);
            check_word(name, "redirect_pc", v.exp_redirect_pc, out_redirect_pc);
            retired++;
        end
    endtask

    task automatic offer_record();
        vector_t v;
        if (sent == num_vectors) begin
            in_valid = 1'b0;
        end else begin
            v = vec_mem[sent];
            if (!holding && v.ext_int[5:0] != ext_int) begin
                // interrupt lines change only with nothing in flight
                in_valid = 1'b0;
                if (retired == sent) begin
                    ext_int = v.ext_int[5:0];
                end
            end else if (!holding && ($urandom % 4) == 0) begin
                in_valid = 1'b0;
            end else begin
                in_pc         = v.pc;
                in_delay_slot = v.delay_slot[0];
                in_kind       = mips_pkg::rec_kind_t'(v.kind[1:0]);
                in_faults     = mips_pkg::fault_t'(v.faults[6:0]);
                in_vaddr      = v.vaddr;
                in_data       = v.data;
                in_valid      = 1'b1;
                if (in_ready) begin
                    sent++;
                    holding = 1'b0;
                end else begin
                    holding = 1'b1;
                end
            end
        end
    endtask

    initial begin : stimulus
        void'($urandom(32'h2b71_f2be));
        $readmemh("testbench/exc_vectors.mem", vec_mem);
        rst_n         = 1'b0;
        ext_int       = '0;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_delay_slot = 1'b0;
        in_kind       = mips_pkg::kind_plain;
        in_faults     = '0;
        in_vaddr      = '0;
        in_data       = '0;
        out_ready     = 1'b0;
        sent          = 0;
        retired       = 0;
        holding       = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("after_reset", "in_ready", 1'b1, in_ready);
        check_flag("after_reset", "out_valid", 1'b0, out_valid);
        while (retired < num_vectors) begin
            @(negedge clk);
            collect_outcome();
            offer_record();
        end
        $display(">>> PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (reset_cycles + num_vectors * cycles_per_vector) @(posedge clk);
        $display("outcomes stopped arriving, %0d of %0d vectors retired", retired, num_vectors);
        abort_run();
    end

endmodule

`default_nettype wire
